/* src/nandDataOutPkg.sv */
package nandDataOutPkg;

    // way select and chip enable
    localparam int NumberOfWays    = 4;
    localparam int ChipEnableWidth = 2 * NumberOfWays; // way mask is sent twice

    // write word and DQ bus, 4 slots of 8 bits
    localparam int DataWidth = 32;

    // pin slots per system cycle on the strobe
    localparam int LaneCount = 8;

    // sub-cycle counter, 10 ns per count
    localparam int TimerWidth = 5;

    localparam logic [TimerWidth-1:0] TcdqssCycles = 5'd25; // 250 ns setup
    localparam logic [TimerWidth-1:0] TwpreCycles  = 5'd30; // 5 more for preamble
    localparam logic [TimerWidth-1:0] TwpstCycles  = 5'd3;  // postamble, well above tWPST

    // bit of iOption that selects the shifted toggle pattern
    localparam int OptionShiftBit = 1;

    // one-hot phase of the data-out step
    typedef enum logic [9:0] {
        PhaseReset     = 10'b00_0000_0001,
        PhaseIdle      = 10'b00_0000_0010,
        PhaseCapture   = 10'b00_0000_0100, // way and option taken in
        PhaseSetup     = 10'b00_0000_1000, // tCDQSS wait, ALE high
        PhasePreamble  = 10'b00_0001_0000, // tWPRE wait, strobe quiet
        PhaseTransfer  = 10'b00_0010_0000,
        PhasePause     = 10'b00_0100_0000, // writer stalled
        PhaseLastWord  = 10'b00_1000_0000,
        PhasePostamble = 10'b01_0000_0000, // tWPST wait
        PhaseDone      = 10'b10_0000_0000
    } phase_t;

    // strobe patterns, one bit per pin slot
    localparam logic [LaneCount-1:0] StrobeIdle    = 8'b1111_1111;
    localparam logic [LaneCount-1:0] StrobeQuiet   = 8'b0000_0000;

    // two edges per system cycle, one per half word
    localparam logic [LaneCount-1:0] StrobeShifted = 8'b1100_1100;
    localparam logic [LaneCount-1:0] StrobeNormal  = 8'b0110_0110;

endpackage

/* src/phyTimer.sv */
`timescale 1ns/1ns

module phyTimer (
    input  logic                   iSystemClock,
    input  logic                   iReset,
    input  logic                   iClear,
    input  logic                   iRun,
    input  nandDataOutPkg::phase_t iPhase,
    output logic                   oSetupDone,
    output logic                   oPreambleDone,
    output logic                   oPostambleDone
);
    import nandDataOutPkg::*;

    logic [TimerWidth-1:0] rCount;

    // clear wins over run, otherwise hold
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            rCount <= '0;
        end else if (iClear) begin
            rCount <= '0;
        end else if (iRun) begin
            rCount <= rCount + 1'b1;
        end
    end

    assign oSetupDone = (iPhase == PhaseSetup) && (rCount == TcdqssCycles);

    // count stays at the preamble end while words flow
    assign oPreambleDone = (iPhase inside {PhasePreamble, PhaseTransfer, PhasePause})
                           && (rCount == TwpreCycles);

    assign oPostambleDone = (iPhase == PhasePostamble) && (rCount == TwpstCycles);

endmodule

/* src/dataOutSequencer.sv */
`timescale 1ns/1ns

module dataOutSequencer (
    input  logic                   iSystemClock,
    input  logic                   iReset,
    input  logic                   iStart,
    input  logic                   iSetupDone,
    input  logic                   iPreambleDone,
    input  logic                   iPostambleDone,
    input  logic                   iWriteValid,
    input  logic                   iWordLast,
    input  logic                   iSecondHalf,
    output nandDataOutPkg::phase_t oPhase,
    output logic                   oTimerClear,
    output logic                   oTimerRun,
    output logic                   oReady,
    output logic                   oLastStep
);
    import nandDataOutPkg::*;

    phase_t rPhase;
    phase_t wNextPhase;
    phase_t wWordPhase;
    logic   rReady;
    logic   rLastStep;

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            rPhase <= PhaseReset;
        end else begin
            rPhase <= wNextPhase;
        end
    end

    // where to go once a word may be taken
    always_comb begin
        if (iWordLast) begin
            wWordPhase = PhaseLastWord;
        end else if (iWriteValid) begin
            wWordPhase = PhaseTransfer;
        end else begin
            wWordPhase = PhasePause;
        end
    end

    always_comb begin
        case (rPhase)
            PhaseReset: begin
                wNextPhase = PhaseIdle;
            end
            PhaseIdle: begin
                wNextPhase = iStart ? PhaseCapture : PhaseIdle;
            end
            PhaseCapture: begin
                wNextPhase = PhaseSetup;
            end
            PhaseSetup: begin
                wNextPhase = iSetupDone ? PhasePreamble : PhaseSetup;
            end
            PhasePreamble: begin
                wNextPhase = iPreambleDone ? wWordPhase : PhasePreamble;
            end
            PhaseTransfer: begin
                // upper half still to go out
                wNextPhase = iSecondHalf ? PhaseTransfer : wWordPhase;
            end
            PhasePause: begin
                wNextPhase = wWordPhase;
            end
            PhaseLastWord: begin
                wNextPhase = iSecondHalf ? PhaseLastWord : PhasePostamble;
            end
            PhasePostamble: begin
                wNextPhase = iPostambleDone ? PhaseDone : PhasePostamble;
            end
            PhaseDone: begin
                wNextPhase = iStart ? PhaseCapture : PhaseIdle; // back-to-back burst
            end
            default: begin
                wNextPhase = PhaseIdle;
            end
        endcase
    end

    // counter restarts for setup and for postamble, holds during data
    assign oTimerClear = wNextPhase inside {PhaseReset, PhaseIdle, PhaseCapture, PhaseLastWord};
    assign oTimerRun   = wNextPhase inside {PhaseSetup, PhasePreamble, PhasePostamble};

    // flags line up with the phase they belong to
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            rReady    <= 1'b0;
            rLastStep <= 1'b0;
        end else begin
            rReady    <= wNextPhase inside {PhaseIdle, PhaseDone};
            rLastStep <= (wNextPhase == PhaseDone);
        end
    end

    assign oPhase    = rPhase;
    assign oReady    = rReady;
    assign oLastStep = rLastStep;

endmodule

/* src/dqSerializer.sv */
`timescale 1ns/1ns

module dqSerializer (
    input  logic                                 iSystemClock,
    input  logic                                 iReset,
    input  nandDataOutPkg::phase_t               iPhase,
    input  logic                                 iPreambleDone,
    input  logic [nandDataOutPkg::DataWidth-1:0] iWriteData,
    input  logic                                 iWriteValid,
    input  logic                                 iWriteLast,
    output logic                                 oWriteReady,
    output logic                                 oWordLast,
    output logic                                 oSecondHalf,
    output logic [nandDataOutPkg::DataWidth-1:0] oDq
);
    import nandDataOutPkg::*;

    logic                 rSecondHalf;
    logic [DataWidth-1:0] rDq;
    logic                 wAccept;

    // no new word while the upper half is pending
    assign oWriteReady = iPreambleDone & ~rSecondHalf;
    assign wAccept     = iWriteValid & oWriteReady;
    assign oWordLast   = wAccept & iWriteLast;

    // high for the cycle that shows a freshly taken word
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            rSecondHalf <= 1'b0;
        end else begin
            rSecondHalf <= wAccept;
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (wAccept) begin
            rDq <= iWriteData;
        end else if (rSecondHalf) begin
            // DDR: upper half on both edges
            rDq <= {2{rDq[DataWidth-1 -: DataWidth/2]}};
        end else if (iPhase inside {PhaseTransfer, PhasePause}) begin
            rDq <= {(DataWidth/8){rDq[DataWidth-1 -: 8]}}; // stalled, park on top byte
        end else begin
            rDq <= '0;
        end
    end

    assign oSecondHalf = rSecondHalf;
    assign oDq         = rDq;

endmodule

/* src/pinDriver.sv */
`timescale 1ns/1ns

module pinDriver (
    input  logic                                       iSystemClock,
    input  logic                                       iReset,
    input  nandDataOutPkg::phase_t                     iPhase,
    input  logic                                       iStart,
    input  logic [2:0]                                 iOption,
    input  logic [nandDataOutPkg::NumberOfWays-1:0]    iTargetWay,
    output logic [nandDataOutPkg::LaneCount-1:0]       oDqStrobe,
    output logic [nandDataOutPkg::ChipEnableWidth-1:0] oChipEnable,
    output logic [3:0]                                 oAddressLatchEnable,
    output logic                                       oDqsOutEnable,
    output logic                                       oDqOutEnable
);
    import nandDataOutPkg::*;

    logic                       rShift;
    logic [ChipEnableWidth-1:0] rChipEnable;
    logic                       wStartTaken;
    logic                       wStartWindow;

    assign wStartWindow = iPhase inside {PhaseIdle, PhaseDone};
    assign wStartTaken  = iStart & wStartWindow;

    // burst options, valid from the capture phase on
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            rShift      <= 1'b0;
            rChipEnable <= '0;
        end else if (wStartTaken) begin
            rShift      <= iOption[OptionShiftBit];
            rChipEnable <= {iTargetWay, iTargetWay};
        end else if (wStartWindow) begin
            rChipEnable <= '0; // release the way when going idle
        end
    end

    // pin levels decoded from the one-hot phase register
    always_comb begin
        case (iPhase)
            PhasePreamble, PhasePause, PhasePostamble, PhaseDone: begin
                oDqStrobe = StrobeQuiet;
            end
            PhaseTransfer, PhaseLastWord: begin
                oDqStrobe = rShift ? StrobeShifted : StrobeNormal;
            end
            default: begin
                oDqStrobe = StrobeIdle;
            end
        endcase
    end

    assign oAddressLatchEnable = (iPhase inside {PhaseCapture, PhaseSetup}) ? 4'b1111 : 4'b0000;

    // DQ released at postamble, DQS held until idle
    assign oDqOutEnable  = iPhase inside {PhaseCapture, PhaseSetup, PhasePreamble,
                                          PhaseTransfer, PhasePause, PhaseLastWord};
    assign oDqsOutEnable = !(iPhase inside {PhaseReset, PhaseIdle});

    assign oChipEnable = rChipEnable;

endmodule

/* src/nandDataOutTop.sv */
`timescale 1ns/1ns

module nandDataOutTop (
    input  logic                                       iSystemClock,
    input  logic                                       iReset,
    input  logic                                       iStart,
    input  logic [2:0]                                 iOption,
    input  logic [nandDataOutPkg::NumberOfWays-1:0]    iTargetWay,
    input  logic [nandDataOutPkg::DataWidth-1:0]       iWriteData,
    input  logic                                       iWriteValid,
    input  logic                                       iWriteLast,
    output logic                                       oReady,
    output logic                                       oLastStep,
    output logic                                       oWriteReady,
    output logic [nandDataOutPkg::LaneCount-1:0]       oDqStrobe,
    output logic [nandDataOutPkg::DataWidth-1:0]       oDq,
    output logic [nandDataOutPkg::ChipEnableWidth-1:0] oChipEnable,
    output logic [3:0]                                 oAddressLatchEnable,
    output logic                                       oDqsOutEnable,
    output logic                                       oDqOutEnable
);
    import nandDataOutPkg::*;

    phase_t phase;
    logic   timerClear;
    logic   timerRun;
    logic   setupDone;
    logic   preambleDone;
    logic   postambleDone;
    logic   secondHalf;
    logic   wordLast;

    phyTimer timer (
        .iSystemClock   (iSystemClock),
        .iReset         (iReset),
        .iClear         (timerClear),
        .iRun           (timerRun),
        .iPhase         (phase),
        .oSetupDone     (setupDone),
        .oPreambleDone  (preambleDone),
        .oPostambleDone (postambleDone)
    );

    dataOutSequencer sequencer (
        .iSystemClock   (iSystemClock),
        .iReset         (iReset),
        .iStart         (iStart),
        .iSetupDone     (setupDone),
        .iPreambleDone  (preambleDone),
        .iPostambleDone (postambleDone),
        .iWriteValid    (iWriteValid),
        .iWordLast      (wordLast),
        .iSecondHalf    (secondHalf),
        .oPhase         (phase),
        .oTimerClear    (timerClear),
        .oTimerRun      (timerRun),
        .oReady         (oReady),
        .oLastStep      (oLastStep)
    );

    dqSerializer serializer (
        .iSystemClock  (iSystemClock),
        .iReset        (iReset),
        .iPhase        (phase),
        .iPreambleDone (preambleDone),
        .iWriteData    (iWriteData),
        .iWriteValid   (iWriteValid),
        .iWriteLast    (iWriteLast),
        .oWriteReady   (oWriteReady),
        .oWordLast     (wordLast),
        .oSecondHalf   (secondHalf),
        .oDq           (oDq)
    );

    pinDriver pins (
        .iSystemClock        (iSystemClock),
        .iReset              (iReset),
        .iPhase              (phase),
        .iStart              (iStart),
        .iOption             (iOption),
        .iTargetWay          (iTargetWay),
        .oDqStrobe           (oDqStrobe),
        .oChipEnable         (oChipEnable),
        .oAddressLatchEnable (oAddressLatchEnable),
        .oDqsOutEnable       (oDqsOutEnable),
        .oDqOutEnable        (oDqOutEnable)
    );

endmodule

/* dv/nandDataOut_assert.sv */
`timescale 1ns/1ns

module nandDataOutChecks (
    input logic                                       iSystemClock,
    input logic                                       iReset,
    input logic                                       iWriteValid,
    input logic                                       oWriteReady,
    input logic                                       oReady,
    input logic                                       oLastStep,
    input logic                                       oDqOutEnable,
    input logic                                       oDqsOutEnable,
    input logic [nandDataOutPkg::LaneCount-1:0]       oDqStrobe,
    input logic [nandDataOutPkg::ChipEnableWidth-1:0] oChipEnable,
    input logic [3:0]                                 oAddressLatchEnable
);
    import nandDataOutPkg::*;

    // a taken word blocks the port for one cycle
    assert property (@(posedge iSystemClock) disable iff (iReset)
                     (oWriteReady && iWriteValid) |=> !oWriteReady)
        else $error("write-ready high right after a transfer");

    assert property (@(posedge iSystemClock) disable iff (iReset)
                     oReady |-> !oDqOutEnable)
        else $error("DQ output enable high while start port is ready");

    // ready without last step means idle
    assert property (@(posedge iSystemClock) disable iff (iReset)
                     (oReady && !oLastStep) |-> (oDqStrobe == StrobeIdle
                         && oChipEnable == '0 && oAddressLatchEnable == 4'b0000
                         && !oDqsOutEnable))
        else $error("idle outputs not at rest");

endmodule

bind nandDataOutTop nandDataOutChecks checks (
    .iSystemClock        (iSystemClock),
    .iReset              (iReset),
    .iWriteValid         (iWriteValid),
    .oWriteReady         (oWriteReady),
    .oReady              (oReady),
    .oLastStep           (oLastStep),
    .oDqOutEnable        (oDqOutEnable),
    .oDqsOutEnable       (oDqsOutEnable),
    .oDqStrobe           (oDqStrobe),
    .oChipEnable         (oChipEnable),
    .oAddressLatchEnable (oAddressLatchEnable)
);

/* dv/nandDataOutTb.sv */
`timescale 1ns/1ns

module nandDataOutTb;
    import nandDataOutPkg::*;

    localparam int MaxRows      = 8;
    localparam int MaxWords     = 8;
    localparam int StartTimeout = 50;
    localparam int BurstTimeout = 200;

    logic                       iSystemClock;
    logic                       iReset;
    logic                       iStart;
    logic [2:0]                 iOption;
    logic [NumberOfWays-1:0]    iTargetWay;
    logic [DataWidth-1:0]       iWriteData;
    logic                       iWriteValid;
    logic                       iWriteLast;
    logic                       oReady;
    logic                       oLastStep;
    logic                       oWriteReady;
    logic [LaneCount-1:0]       oDqStrobe;
    logic [DataWidth-1:0]       oDq;
    logic [ChipEnableWidth-1:0] oChipEnable;
    logic [3:0]                 oAddressLatchEnable;
    logic                       oDqsOutEnable;
    logic                       oDqOutEnable;

    // stimulus table with one burst per row
    string                   testName  [MaxRows];
    logic [NumberOfWays-1:0] rowWay    [MaxRows];
    logic [2:0]              rowOption [MaxRows];
    int                      rowCount  [MaxRows];
    logic [MaxWords-1:0]     rowStall  [MaxRows]; // bit i holds word i back once
    logic [DataWidth-1:0]    rowFirst  [MaxRows];
    int                      rowTotal;

    logic [DataWidth-1:0] words [MaxWords];
    string                currentName;
    int                   errorCount;
    int                   checkCount;
    bit                   timedOut;

    nandDataOutTop dut (
        .iSystemClock        (iSystemClock),
        .iReset              (iReset),
        .iStart              (iStart),
        .iOption             (iOption),
        .iTargetWay          (iTargetWay),
        .iWriteData          (iWriteData),
        .iWriteValid         (iWriteValid),
        .iWriteLast          (iWriteLast),
        .oReady              (oReady),
        .oLastStep           (oLastStep),
        .oWriteReady         (oWriteReady),
        .oDqStrobe           (oDqStrobe),
        .oDq                 (oDq),
        .oChipEnable         (oChipEnable),
        .oAddressLatchEnable (oAddressLatchEnable),
        .oDqsOutEnable       (oDqsOutEnable),
        .oDqOutEnable        (oDqOutEnable)
    );

    initial iSystemClock = 1'b0;
    always #2 iSystemClock = ~iSystemClock;

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("ERROR %s %s: expected %h, actual %h", currentName, what, expected, actual);
        end
    endtask

    task automatic addRow(input string name, input logic [NumberOfWays-1:0] way,
                          input logic [2:0] option, input int count,
                          input logic [MaxWords-1:0] stall, input logic [DataWidth-1:0] first);
        testName[rowTotal]  = name;
        rowWay[rowTotal]    = way;
        rowOption[rowTotal] = option;
        rowCount[rowTotal]  = count;
        rowStall[rowTotal]  = stall;
        rowFirst[rowTotal]  = first;
        rowTotal++;
    endtask

    // waits for the start window, then requests a burst
    task automatic startBurst(input int row);
        int waited;
        waited      = 0;
        currentName = testName[row];
        while (!oReady && waited < StartTimeout) begin
            @(negedge iSystemClock);
            waited++;
        end
        if (!oReady) begin
            $display("timeout: oReady never came back before test %s", currentName);
            errorCount++;
            timedOut = 1'b1;
        end else begin
            iStart      = 1'b1;
            iOption     = rowOption[row];
            iTargetWay  = rowWay[row];
            iWriteValid = 1'b0;
            words[0]    = rowFirst[row];
            for (int i = 1; i < MaxWords; i++) begin
                words[i] = $urandom();
            end
        end
    endtask

    task automatic runBurst(input int row);
        int                   cycle;
        int                   idx;
        int                   stage;   // 1 word shown, 2 upper half, 3 pause
        int                   firstReady;
        bit                   stallUsed;
        bit                   accept;
        bit                   done;
        logic [DataWidth-1:0] shown;
        logic [LaneCount-1:0] toggle;
        cycle      = 0;
        idx        = 0;
        stage      = 0;
        firstReady = 0;
        stallUsed  = 1'b0;
        done       = 1'b0;
        shown      = '0;
        toggle     = rowOption[row][OptionShiftBit] ? StrobeShifted : StrobeNormal;
        while (!done && cycle < BurstTimeout) begin
            @(negedge iSystemClock);
            cycle++;
            iStart = 1'b0;
            compareValue("chip enable", {rowWay[row], rowWay[row]}, oChipEnable);
            compareValue("DQS enable in burst", 1'b1, oDqsOutEnable);
            if (cycle == 1) begin
                compareValue("ALE in capture", 4'b1111, oAddressLatchEnable);
                compareValue("last step in capture", 1'b0, oLastStep);
                compareValue("DQ enable in capture", 1'b1, oDqOutEnable);
            end
            if (oWriteReady && firstReady == 0) begin
                firstReady = cycle;
                if (cycle < int'(TwpreCycles)) begin
                    errorCount++;
                    $display("write-ready in %s came %0d cycles after start, too early",
                             currentName, cycle);
                end
            end
            if (firstReady != 0) begin
                compareValue("ALE after write-ready", 4'b0000, oAddressLatchEnable);
            end
            case (stage)
                1: begin
                    compareValue("word", shown, oDq);
                    compareValue("strobe", toggle, oDqStrobe);
                    compareValue("write-ready in first half", 1'b0, oWriteReady);
                end
                2: begin
                    compareValue("upper half", {2{shown[31:16]}}, oDq);
                    compareValue("strobe", toggle, oDqStrobe);
                end
                3: begin
                    compareValue("pause DQ", {4{shown[31:24]}}, oDq);
                    compareValue("pause strobe", StrobeQuiet, oDqStrobe);
                end
                default: begin
                end
            endcase
            if (idx == rowCount[row] && oWriteReady) begin
                errorCount++;
                $display("write-ready high in %s after the last word", currentName);
            end
            if (oLastStep) begin
                done = 1'b1;
                compareValue("oReady with last step", 1'b1, oReady);
                compareValue("words accepted", rowCount[row], idx);
                compareValue("DQ enable at last step", 1'b0, oDqOutEnable);
            end
            accept      = 1'b0;
            iWriteValid = 1'b0;
            iWriteLast  = 1'b0;
            if (!done && idx < rowCount[row]) begin
                if (rowStall[row][idx] && !stallUsed) begin
                    if (oWriteReady) stallUsed = 1'b1; // writer skips one chance
                end else begin
                    iWriteValid = 1'b1;
                    iWriteData  = words[idx];
                    iWriteLast  = (idx == rowCount[row] - 1);
                    accept      = oWriteReady;
                end
            end
            if (accept) begin
                shown     = words[idx];
                idx++;
                stallUsed = 1'b0;
                stage     = 1;
            end else if (stage == 1) begin
                stage = 2;
            end else if (oWriteReady && idx < rowCount[row]) begin
                stage = 3;
            end else begin
                stage = 0;
            end
        end
        if (!done) begin
            $display("timeout: burst %s never reached its last step", currentName);
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    initial begin
        int row;
        errorCount  = 0;
        checkCount  = 0;
        timedOut    = 1'b0;
        rowTotal    = 0;
        currentName = "reset";
        void'($urandom(32'he23e));
        iReset      = 1'b1;
        iStart      = 1'b0;
        iOption     = '0;
        iTargetWay  = '0;
        iWriteData  = '0;
        iWriteValid = 1'b0;
        iWriteLast  = 1'b0;

        addRow("single",     4'b0001, 3'b000, 1, 8'b0000_0000, 32'ha5a5_0f0f);
        addRow("shifted",    4'b0010, 3'b010, 4, 8'b0000_0000, 32'h1234_5678);
        addRow("stallFirst", 4'b0100, 3'b000, 3, 8'b0000_0001, 32'hdead_beef);
        addRow("stallMid",   4'b1000, 3'b110, 5, 8'b0001_0100, 32'h8001_7ffe);
        addRow("manyWays",   4'b1011, 3'b011, 8, 8'b1010_0010, 32'hc3c3_3c3c);

        repeat (10) @(negedge iSystemClock);
        compareValue("oReady in reset", 1'b0, oReady);
        compareValue("write-ready in reset", 1'b0, oWriteReady);
        compareValue("last step in reset", 1'b0, oLastStep);
        iReset = 1'b0;
        @(negedge iSystemClock);
        currentName = "afterReset";
        compareValue("oReady", 1'b1, oReady);
        compareValue("strobe", StrobeIdle, oDqStrobe);
        compareValue("chip enable", '0, oChipEnable);
        compareValue("ALE", 4'b0000, oAddressLatchEnable);
        compareValue("DQS enable", 1'b0, oDqsOutEnable);
        compareValue("DQ enable", 1'b0, oDqOutEnable);

        // later rows start straight from the done cycle
        for (row = 0; row < rowTotal && !timedOut; row++) begin
            startBurst(row);
            if (!timedOut) runBurst(row);
        end
        if (!timedOut) begin
            @(negedge iSystemClock);
            currentName = "afterLast";
            compareValue("last step after done", 1'b0, oLastStep);
        end

        $display("checks %0d, errors %0d, timeout %0d", checkCount, errorCount, timedOut);
        if (errorCount == 0 && !timedOut) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* all.f */
src/nandDataOutPkg.sv
src/phyTimer.sv
src/dataOutSequencer.sv
src/dqSerializer.sv
src/pinDriver.sv
src/nandDataOutTop.sv
dv/nandDataOut_assert.sv
dv/nandDataOutTb.sv
